// ==== design/dsi_defs.svh ====
////////////////////////////////////////
// DSI core constants
// register map, lane count and the
// clock lane HS pattern
////////////////////////////////////////

`ifndef DSI_DEFS_SVH
`define DSI_DEFS_SVH

// data lanes, clock lane not counted
`define DSI_NUM_LANES 3

// host register addresses
`define DSI_REG_TICK_DIV  6'd0
`define DSI_REG_CTL       6'd1
`define DSI_REG_LP_TX     6'd2
`define DSI_REG_GPIO      6'd3
`define DSI_REG_LANE_CTRL 6'd4

// byte sent by the clock lane in HS mode
`define DSI_CLK_PATTERN 8'hAA

`endif

// ==== design/dsi_pkg.sv ====
////////////////////////////////////////
// DSI core types
// lane payload, lane select, LP line
// pair and host register address
////////////////////////////////////////

package dsi_pkg;

   // one serdes byte per lane per byte clock
   typedef logic [7:0] lane_byte_t;

   // picks one of the four HS input bytes
   typedef logic [1:0] lane_sel_t;

   // low-power line pair of one lane
   typedef struct packed {
      logic p;
      logic n;
   } lp_line_t;

   // host register address
   typedef logic [5:0] reg_addr_t;

endpackage

// ==== design/dsi_lane_ctrl_if.sv ====
////////////////////////////////////////
// DSI lane control interface
// control from the register block to
// one lane, status back
////////////////////////////////////////

`timescale 1ns/100ps

interface dsi_lane_ctrl_if import dsi_pkg::*; ();

   // register block side
   logic       tick;
   logic       hs_req;
   lane_sel_t  lane_sel;
   logic       invert;
   logic       lp_valid;
   lane_byte_t lp_data;

   // lane side
   logic       hs_ready;
   logic       lp_ready;

   modport regs (
      output tick, hs_req, lane_sel, invert, lp_valid, lp_data,
      input  hs_ready, lp_ready
   );

   modport lane (
      input  tick, hs_req, lane_sel, invert, lp_valid, lp_data,
      output hs_ready, lp_ready
   );

endinterface

// ==== design/dsi_csr_regs.sv ====
////////////////////////////////////////
// DSI host register block
// host registers, read-back, tick divider
// and control fan-out to every lane
////////////////////////////////////////

`timescale 1ns/100ps
`include "dsi_defs.svh"

module dsi_csr_regs import dsi_pkg::*; (
   input  logic          clk_dsi_i,
   input  logic          rst_n_dsi,
   input  reg_addr_t     host_addr_i,
   input  logic [31:0]   host_wdata_i,
   input  logic          host_wr_i,
   output logic [31:0]   host_rdata_o,
   dsi_lane_ctrl_if.regs data_lane_o [`DSI_NUM_LANES],
   dsi_lane_ctrl_if.regs clk_lane_o,
   output logic          dsi_reset_n_o,
   output logic [2:0]    dsi_gpio_o
);

   logic [15:0] tick_div_q;
   logic [15:0] tick_cnt_q;
   logic        tick_q;
   logic        clk_en_q;
   logic        hs_req_q;
   logic [2:0]  num_lanes_q;
   logic        lp_valid_q;
   lane_byte_t  lp_data_q;
   logic [7:0]  lane_sel_q;
   logic [3:0]  lane_inv_q;
   logic        clk_inv_q;
   logic        lp_ready0;
   logic [31:0] rd_val;

   // LP transmit is paced by lane 0
   assign lp_ready0 = data_lane_o[0].lp_ready;

   ////////////////////////////////////////
   // tick divider
   ////////////////////////////////////////

   // one tick every tick_div + 1 cycles
   always_ff @(posedge clk_dsi_i) begin
      if (!rst_n_dsi) begin
         tick_cnt_q <= '0;
         tick_q     <= 1'b0;
      end else if (tick_cnt_q >= tick_div_q) begin
         tick_cnt_q <= '0;
         tick_q     <= 1'b1;
      end else begin
         tick_cnt_q <= tick_cnt_q + 16'd1;
         tick_q     <= 1'b0;
      end
   end

   ////////////////////////////////////////
   // host writes
   ////////////////////////////////////////

   always_ff @(posedge clk_dsi_i) begin
      if (!rst_n_dsi) begin
         tick_div_q    <= '0;
         clk_en_q      <= 1'b0;
         hs_req_q      <= 1'b0;
         num_lanes_q   <= '0;
         lp_valid_q    <= 1'b0;
         dsi_reset_n_o <= 1'b0;
         dsi_gpio_o    <= '0;
         lane_sel_q    <= '0;
         lane_inv_q    <= '0;
         clk_inv_q     <= 1'b0;
      end else begin
         lp_valid_q <= 1'b0;
         if (host_wr_i) begin
            case (host_addr_i)
               `DSI_REG_TICK_DIV: tick_div_q <= host_wdata_i[15:0];
               `DSI_REG_CTL: begin
                  clk_en_q    <= host_wdata_i[0];
                  hs_req_q    <= host_wdata_i[1];
                  num_lanes_q <= host_wdata_i[10:8];
               end
               // one byte at a time, dropped while lane 0 is busy
               `DSI_REG_LP_TX:
                  lp_valid_q <= host_wdata_i[8] && lp_ready0 && !lp_valid_q;
               `DSI_REG_GPIO: begin
                  dsi_reset_n_o <= host_wdata_i[0];
                  dsi_gpio_o    <= host_wdata_i[3:1];
               end
               `DSI_REG_LANE_CTRL: begin
                  lane_sel_q <= host_wdata_i[7:0];
                  lane_inv_q <= host_wdata_i[11:8];
                  clk_inv_q  <= host_wdata_i[12];
               end
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk_dsi_i) begin
      if (host_wr_i && host_addr_i == `DSI_REG_LP_TX)
         lp_data_q <= host_wdata_i[7:0];
   end

   ////////////////////////////////////////
   // read-back
   ////////////////////////////////////////

   always_comb begin
      rd_val = '0;
      case (host_addr_i)
         `DSI_REG_CTL: begin
            rd_val[0]    = clk_en_q;
            rd_val[1]    = lp_ready0;
            rd_val[10:8] = num_lanes_q;
         end
         `DSI_REG_GPIO:      rd_val[3:0]  = {dsi_gpio_o, dsi_reset_n_o};
         `DSI_REG_LANE_CTRL: rd_val[12:0] = {clk_inv_q, lane_inv_q, lane_sel_q};
         default: ;
      endcase
   end

   // held during a write cycle
   always_ff @(posedge clk_dsi_i) begin
      if (!rst_n_dsi)
         host_rdata_o <= '0;
      else if (!host_wr_i)
         host_rdata_o <= rd_val;
   end

   ////////////////////////////////////////
   // per-lane control
   ////////////////////////////////////////

   for (genvar i = 0; i < `DSI_NUM_LANES; i++) begin : g_data_lane
      assign data_lane_o[i].tick     = tick_q;
      // only the first num_lanes lanes go to HS
      assign data_lane_o[i].hs_req   = hs_req_q && (num_lanes_q > 3'(i));
      assign data_lane_o[i].lane_sel = lane_sel_q[2*i +: 2];
      assign data_lane_o[i].invert   = lane_inv_q[i];
      assign data_lane_o[i].lp_valid = lp_valid_q && (lane_sel_q[2*i +: 2] == 2'd0);
      assign data_lane_o[i].lp_data  = lp_data_q;
   end

   // clock lane never sends LP bytes
   assign clk_lane_o.tick     = tick_q;
   assign clk_lane_o.hs_req   = clk_en_q;
   assign clk_lane_o.lane_sel = '0;
   assign clk_lane_o.invert   = clk_inv_q;
   assign clk_lane_o.lp_valid = 1'b0;
   assign clk_lane_o.lp_data  = '0;

endmodule

// ==== design/dsi_dphy_lane.sv ====
////////////////////////////////////////
// D-PHY lane
// LP state sequencing into HS, HS byte
// output and bit-serial LP transmit
////////////////////////////////////////

`timescale 1ns/100ps
`include "dsi_defs.svh"

module dsi_dphy_lane import dsi_pkg::*; #(
   parameter bit IS_CLOCK = 1'b0
) (
   input  logic             clk_dsi_i,
   input  logic             rst_n_dsi,
   dsi_lane_ctrl_if.lane    ctrl,
   input  lane_byte_t [3:0] hs_data_i,
   input  logic             hs_valid_i,
   output lane_byte_t       serdes_data_o,
   output logic             serdes_oe_o,
   output lp_line_t         lp_o,
   output logic             lp_oe_o
);

   typedef enum logic [1:0] {
      ST_STOP,
      ST_HS_RQST,
      ST_BRIDGE,
      ST_HS
   } lane_state_t;

   lane_state_t state_q;
   lane_state_t state_d;
   logic        lp_pend_q;
   logic        lp_busy_q;
   logic        lp_idle;
   lane_byte_t  lp_sreg_q;
   logic [2:0]  lp_cnt_q;
   lane_byte_t  hs_byte;
   logic        hs_take;
   lane_byte_t  serdes_q;

   assign lp_idle = !lp_pend_q && !lp_busy_q;

   ////////////////////////////////////////
   // LP state sequencing
   ////////////////////////////////////////

   // one step per tick, stop is left only with no LP byte in flight
   always_comb begin
      state_d = state_q;
      if (ctrl.tick) begin
         case (state_q)
            ST_STOP:
               if (ctrl.hs_req && lp_idle && !ctrl.lp_valid)
                  state_d = ST_HS_RQST;
            ST_HS_RQST: state_d = ctrl.hs_req ? ST_BRIDGE : ST_STOP;
            ST_BRIDGE:  state_d = ctrl.hs_req ? ST_HS : ST_STOP;
            default:
               if (!ctrl.hs_req)
                  state_d = ST_STOP;
         endcase
      end
   end

   always_ff @(posedge clk_dsi_i) begin
      if (!rst_n_dsi)
         state_q <= ST_STOP;
      else
         state_q <= state_d;
   end

   assign lp_oe_o       = (state_q != ST_HS);
   assign serdes_oe_o   = (state_q == ST_HS);
   assign ctrl.hs_ready = (state_q == ST_HS);
   assign ctrl.lp_ready = lp_idle;

   ////////////////////////////////////////
   // LP serial transmit
   ////////////////////////////////////////

   // wait for the next tick, then 8 bits msb first
   always_ff @(posedge clk_dsi_i) begin
      if (!rst_n_dsi) begin
         lp_pend_q <= 1'b0;
         lp_busy_q <= 1'b0;
         lp_cnt_q  <= '0;
      end else if (ctrl.lp_valid && lp_idle) begin
         lp_pend_q <= 1'b1;
      end else if (ctrl.tick && lp_pend_q) begin
         lp_pend_q <= 1'b0;
         lp_busy_q <= 1'b1;
         lp_cnt_q  <= '0;
      end else if (ctrl.tick && lp_busy_q) begin
         if (lp_cnt_q == 3'd7)
            lp_busy_q <= 1'b0;
         lp_cnt_q <= lp_cnt_q + 3'd1;
      end
   end

   always_ff @(posedge clk_dsi_i) begin
      if (ctrl.lp_valid && lp_idle)
         lp_sreg_q <= ctrl.lp_data;
      else if (ctrl.tick && lp_busy_q)
         lp_sreg_q <= {lp_sreg_q[6:0], 1'b0};
   end

   // line levels per state
   always_comb begin
      case (state_q)
         ST_STOP: begin
            lp_o.p = lp_busy_q ? lp_sreg_q[7] : 1'b1;
            lp_o.n = lp_busy_q ? !lp_sreg_q[7] : 1'b1;
         end
         ST_HS_RQST: begin
            lp_o.p = 1'b0;
            lp_o.n = 1'b1;
         end
         default: begin
            lp_o.p = 1'b0;
            lp_o.n = 1'b0;
         end
      endcase
   end

   ////////////////////////////////////////
   // HS byte output
   ////////////////////////////////////////

   always_comb begin
      if (IS_CLOCK) begin
         hs_byte = `DSI_CLK_PATTERN;
         hs_take = 1'b1;
      end else begin
         hs_byte = hs_data_i[ctrl.lane_sel];
         hs_take = hs_valid_i;
      end
   end

   // keyed on the next state so the byte is zero outside HS
   always_ff @(posedge clk_dsi_i) begin
      if (!rst_n_dsi)
         serdes_q <= '0;
      else if (state_d == ST_HS && hs_take)
         serdes_q <= hs_byte ^ {8{ctrl.invert}};
      else
         serdes_q <= '0;
   end

   assign serdes_data_o = serdes_q;

endmodule

// ==== design/dsi_core.sv ====
////////////////////////////////////////
// DSI core top level
// register block, data lanes and the
// clock lane
////////////////////////////////////////

`timescale 1ns/100ps
`include "dsi_defs.svh"

module dsi_core import dsi_pkg::*; (
   input  logic                    clk_dsi_i,
   input  logic                    rst_n_dsi,
   input  reg_addr_t               host_addr_i,
   input  logic [31:0]             host_wdata_i,
   input  logic                    host_wr_i,
   output logic [31:0]             host_rdata_o,
   input  lane_byte_t [3:0]        hs_data_i,
   input  logic                    hs_valid_i,
   output lane_byte_t [3:0]        serdes_data_o,
   output logic [3:0]              serdes_oe_o,
   output logic [`DSI_NUM_LANES-1:0] dsi_lp_p_o,
   output logic [`DSI_NUM_LANES-1:0] dsi_lp_n_o,
   output logic [`DSI_NUM_LANES-1:0] dsi_lp_oe_o,
   output logic                    dsi_clk_lp_p_o,
   output logic                    dsi_clk_lp_n_o,
   output logic                    dsi_clk_lp_oe_o,
   output logic                    dsi_reset_n_o,
   output logic [2:0]              dsi_gpio_o
);

   lp_line_t data_lp [`DSI_NUM_LANES];
   lp_line_t clk_lp;

   dsi_lane_ctrl_if data_ctrl [`DSI_NUM_LANES] ();
   dsi_lane_ctrl_if clk_ctrl ();

   dsi_csr_regs csr_i (
      .clk_dsi_i     (clk_dsi_i),
      .rst_n_dsi     (rst_n_dsi),
      .host_addr_i   (host_addr_i),
      .host_wdata_i  (host_wdata_i),
      .host_wr_i     (host_wr_i),
      .host_rdata_o  (host_rdata_o),
      .data_lane_o   (data_ctrl),
      .clk_lane_o    (clk_ctrl),
      .dsi_reset_n_o (dsi_reset_n_o),
      .dsi_gpio_o    (dsi_gpio_o)
   );

   ////////////////////////////////////////
   // data lanes
   ////////////////////////////////////////

   for (genvar i = 0; i < `DSI_NUM_LANES; i++) begin : g_lane
      dsi_dphy_lane #(.IS_CLOCK(1'b0)) lane_i (
         .clk_dsi_i     (clk_dsi_i),
         .rst_n_dsi     (rst_n_dsi),
         .ctrl          (data_ctrl[i]),
         .hs_data_i     (hs_data_i),
         .hs_valid_i    (hs_valid_i),
         .serdes_data_o (serdes_data_o[i]),
         .serdes_oe_o   (serdes_oe_o[i]),
         .lp_o          (data_lp[i]),
         .lp_oe_o       (dsi_lp_oe_o[i])
      );

      assign dsi_lp_p_o[i] = data_lp[i].p;
      assign dsi_lp_n_o[i] = data_lp[i].n;
   end

   // clock lane takes the last serdes byte
   dsi_dphy_lane #(.IS_CLOCK(1'b1)) clk_lane_i (
      .clk_dsi_i     (clk_dsi_i),
      .rst_n_dsi     (rst_n_dsi),
      .ctrl          (clk_ctrl),
      .hs_data_i     (hs_data_i),
      .hs_valid_i    (hs_valid_i),
      .serdes_data_o (serdes_data_o[`DSI_NUM_LANES]),
      .serdes_oe_o   (serdes_oe_o[`DSI_NUM_LANES]),
      .lp_o          (clk_lp),
      .lp_oe_o       (dsi_clk_lp_oe_o)
   );

   assign dsi_clk_lp_p_o = clk_lp.p;
   assign dsi_clk_lp_n_o = clk_lp.n;

endmodule

// ==== tb/dsi_core_props.sv ====
////////////////////////////////////////
// D-PHY lane line state properties
// bound to every lane of the DSI core
////////////////////////////////////////

`timescale 1ns/100ps

module dsi_core_props import dsi_pkg::*; (
   input logic     clk_dsi_i,
   input logic     rst_n_dsi,
   input lp_line_t lp_i,
   input logic     lp_oe_i,
   input logic     serdes_oe_i
);

   logic [1:0] lines;

   // failed assertions on this lane
   int unsigned fail_cnt = 0;

   assign lines = {lp_i.p, lp_i.n};

   // stop must pass through HS-request before bridge
   a_no_stop_to_bridge: assert property (
      @(posedge clk_dsi_i) disable iff (!rst_n_dsi)
      (lines == 2'b11) |=> (lines != 2'b00)
   ) else begin
      $error("lane lines went from 1/1 straight to 0/0");
      fail_cnt++;
   end

   // HS and LP drivers never on together
   a_oe_exclusive: assert property (
      @(posedge clk_dsi_i) disable iff (!rst_n_dsi)
      !(serdes_oe_i && lp_oe_i)
   ) else begin
      $error("serdes_oe and lp_oe are both high");
      fail_cnt++;
   end

   // LP levels outside HS are always driven
   a_lp_driven: assert property (
      @(posedge clk_dsi_i) disable iff (!rst_n_dsi)
      (!serdes_oe_i && lines != 2'b00) |-> lp_oe_i
   ) else begin
      $error("LP lines not driven while outside HS");
      fail_cnt++;
   end

endmodule

bind dsi_dphy_lane dsi_core_props props_i (
   .clk_dsi_i   (clk_dsi_i),
   .rst_n_dsi   (rst_n_dsi),
   .lp_i        (lp_o),
   .lp_oe_i     (lp_oe_o),
   .serdes_oe_i (serdes_oe_o)
);

// ==== tb/dsi_core_tb.sv ====
////////////////////////////////////////
// DSI core testbench
// register access, LP transmit, HS entry,
// HS byte streaming and return to stop
////////////////////////////////////////

`timescale 1ns/100ps
`include "dsi_defs.svh"

module dsi_core_tb import dsi_pkg::*; ();

   localparam int CLK_PERIOD  = 10;
   localparam int HS_BEATS    = 16;
   localparam int NUM_ENTRIES = 4;

   typedef struct packed {
      logic [15:0] tick_div;
      logic [3:0]  gpio;
      logic [12:0] lane_ctrl;
      logic        clk_en;
      logic [2:0]  num_lanes;
      logic        lp_en;
      lane_byte_t  lp_byte;
      logic [2:0]  exp_active;
      lane_byte_t  exp_clk_byte;
   } entry_t;

   // div, gpio, lane_ctrl, clk_en, num_lanes, lp_en, lp_byte, active lanes, clock byte
   localparam entry_t TESTS [NUM_ENTRIES] = '{
      '{16'd0, 4'hB, 13'h0218, 1'b1, 3'd2, 1'b0, 8'h00, 3'b011, 8'hAA},
      '{16'd3, 4'h5, 13'h1130, 1'b1, 3'd3, 1'b1, 8'hA5, 3'b111, 8'h55},
      '{16'd3, 4'hE, 13'h040C, 1'b0, 3'd1, 1'b1, 8'h3C, 3'b001, 8'h00},
      '{16'd1, 4'h0, 13'h1E1B, 1'b1, 3'd4, 1'b0, 8'h00, 3'b111, 8'h55}
   };

   logic                          clk_dsi_i;
   logic                          rst_n_dsi;
   reg_addr_t                     host_addr_i;
   logic [31:0]                   host_wdata_i;
   logic                          host_wr_i;
   logic [31:0]                   host_rdata_o;
   lane_byte_t [3:0]              hs_data_i;
   logic                          hs_valid_i;
   lane_byte_t [3:0]              serdes_data_o;
   logic [3:0]                    serdes_oe_o;
   logic [`DSI_NUM_LANES-1:0]     dsi_lp_p_o;
   logic [`DSI_NUM_LANES-1:0]     dsi_lp_n_o;
   logic [`DSI_NUM_LANES-1:0]     dsi_lp_oe_o;
   logic                          dsi_clk_lp_p_o;
   logic                          dsi_clk_lp_n_o;
   logic                          dsi_clk_lp_oe_o;
   logic                          dsi_reset_n_o;
   logic [2:0]                    dsi_gpio_o;
   int unsigned                   lcg_state = 27;

   dsi_core dut_i (.*);

   initial clk_dsi_i = 1'b0;
   always #(CLK_PERIOD / 2) clk_dsi_i = ~clk_dsi_i;

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // lanes 0..2 are data lanes, 3 is the clock lane
   function automatic logic [1:0] line_pair(input int i);
      if (i < `DSI_NUM_LANES)
         return {dsi_lp_p_o[i], dsi_lp_n_o[i]};
      return {dsi_clk_lp_p_o, dsi_clk_lp_n_o};
   endfunction

   // register access, LP byte, HS entry, stream and exit
   function automatic int entry_cycles(input int div);
      return 40 + HS_BEATS + 16 * (div + 1);
   endfunction

   // failures of the assertions bound to every lane
   function automatic int unsigned count_assert_failures();
      return dut_i.g_lane[0].lane_i.props_i.fail_cnt
           + dut_i.g_lane[1].lane_i.props_i.fail_cnt
           + dut_i.g_lane[2].lane_i.props_i.fail_cnt
           + dut_i.clk_lane_i.props_i.fail_cnt;
   endfunction

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped at %0t", $time);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
         stop_run($sformatf("Mismatch on %s: got 0x%0h, expected 0x%0h", name, got, exp));
   endtask

   task automatic write_reg(input reg_addr_t addr, input logic [31:0] data);
      host_addr_i  = addr;
      host_wdata_i = data;
      host_wr_i    = 1'b1;
      @(negedge clk_dsi_i);
      host_wr_i = 1'b0;
   endtask

   task automatic read_reg(input reg_addr_t addr, output logic [31:0] data);
      host_addr_i = addr;
      host_wr_i   = 1'b0;
      @(negedge clk_dsi_i);
      data = host_rdata_o;
   endtask

   task automatic send_lp(input entry_t e);
      int period;
      int cyc;
      logic [1:0] exp_pair;
      period = e.tick_div + 1;
      write_reg(`DSI_REG_LP_TX, {23'd0, 1'b1, e.lp_byte});
      // lp_ready is watched on the CTL read-back
      host_addr_i = `DSI_REG_CTL;
      cyc = 0;
      while (line_pair(0) == 2'b11 && cyc < 4 * period + 4) begin
         @(negedge clk_dsi_i);
         cyc++;
      end
      if (line_pair(0) == 2'b11)
         stop_run("LP transmit never started on lane 0");
      repeat (period / 2) @(negedge clk_dsi_i);
      for (int b = 7; b >= 0; b--) begin
         for (int i = 0; i < `DSI_NUM_LANES; i++) begin
            exp_pair = 2'b11;
            if (e.lane_ctrl[2*i +: 2] == 2'd0)
               exp_pair = {e.lp_byte[b], !e.lp_byte[b]};
            check_value($sformatf("lp lines lane %0d bit %0d", i, b), line_pair(i), exp_pair);
         end
         check_value("host_rdata_o lp_ready busy", host_rdata_o[1], 1'b0);
         repeat (period) @(negedge clk_dsi_i);
      end
      for (int i = 0; i < `DSI_NUM_LANES; i++)
         check_value($sformatf("lp lines lane %0d after LP", i), line_pair(i), 2'b11);
      @(negedge clk_dsi_i);
      check_value("host_rdata_o lp_ready idle", host_rdata_o[1], 1'b1);
   endtask

   task automatic wait_hs_entry(input entry_t e);
      logic [3:0] act;
      logic [1:0] pair;
      int step [4];
      int limit;
      act   = {e.clk_en, e.exp_active};
      limit = 6 * (e.tick_div + 1) + 4;
      foreach (step[i])
         step[i] = 0;
      for (int cyc = 0; cyc <= limit; cyc++) begin
         for (int i = 0; i < 4; i++) begin
            pair = line_pair(i);
            if (!act[i]) begin
               check_value($sformatf("lp lines idle lane %0d", i), pair, 2'b11);
               check_value($sformatf("serdes_oe_o[%0d]", i), serdes_oe_o[i], 1'b0);
            end else if (serdes_oe_o[i]) begin
               if (step[i] != 2)
                  stop_run($sformatf("lane %0d reached HS without 0/1 and 0/0 first", i));
            end else if (pair == 2'b01 && step[i] <= 1) begin
               step[i] = 1;
            end else if (pair == 2'b00 && step[i] >= 1) begin
               step[i] = 2;
            end else if (!(pair == 2'b11 && step[i] == 0)) begin
               stop_run($sformatf("lane %0d showed lines %b out of order", i, pair));
            end
         end
         if ((serdes_oe_o & act) == act)
            break;
         @(negedge clk_dsi_i);
      end
      if ((serdes_oe_o & act) != act)
         stop_run("timeout waiting for the lanes to reach HS");
   endtask

   task automatic stream_hs(input entry_t e);
      lane_byte_t [3:0] prev_data;
      logic             prev_valid;
      logic [31:0]      r;
      lane_byte_t       exp_byte;
      lane_sel_t        sel;
      prev_data  = '0;
      prev_valid = 1'b0;
      for (int k = 0; k <= HS_BEATS; k++) begin
         for (int i = 0; i < `DSI_NUM_LANES; i++) begin
            sel      = e.lane_ctrl[2*i +: 2];
            exp_byte = 8'h00;
            if (e.exp_active[i] && prev_valid)
               exp_byte = prev_data[sel] ^ {8{e.lane_ctrl[8+i]}};
            check_value($sformatf("serdes_data_o[%0d]", i), serdes_data_o[i], exp_byte);
         end
         check_value("serdes_data_o[3]", serdes_data_o[3], e.exp_clk_byte);
         check_value("serdes_oe_o", serdes_oe_o, {e.clk_en, e.exp_active});
         // LP drivers off on every lane in HS
         check_value("lp_oe in HS", {dsi_clk_lp_oe_o, dsi_lp_oe_o},
                     {~e.clk_en, ~e.exp_active});
         // next beat, the last one leaves the input idle
         for (int j = 0; j < 4; j++) begin
            r = lcg_next();
            hs_data_i[j] = r[23:16];
         end
         r = lcg_next();
         hs_valid_i = (k < HS_BEATS) && (r[31:30] != 2'b00);
         prev_data  = hs_data_i;
         prev_valid = hs_valid_i;
         @(negedge clk_dsi_i);
      end
   endtask

   task automatic wait_stop(input entry_t e);
      int cyc;
      cyc = 0;
      while (serdes_oe_o != 4'd0 && cyc < 3 * (e.tick_div + 1) + 4) begin
         @(negedge clk_dsi_i);
         cyc++;
      end
      if (serdes_oe_o != 4'd0)
         stop_run("timeout waiting for the lanes to leave HS");
      check_value("lp lines after HS",
                  {dsi_lp_p_o, dsi_lp_n_o, dsi_clk_lp_p_o, dsi_clk_lp_n_o}, 8'hFF);
      check_value("lp_oe after HS", {dsi_clk_lp_oe_o, dsi_lp_oe_o}, 4'hF);
      check_value("serdes_data_o after HS", serdes_data_o, 32'd0);
   endtask

   task automatic run_entry(input entry_t e);
      logic [31:0] rdata;
      logic [31:0] ctl_wr;
      logic [31:0] ctl_rd;
      ctl_wr = {21'd0, e.num_lanes, 6'd0, 1'b1, e.clk_en};
      // bit 1 reads back lane 0 lp_ready, idle here
      ctl_rd = {21'd0, e.num_lanes, 6'd0, 1'b1, e.clk_en};
      write_reg(`DSI_REG_TICK_DIV, {16'd0, e.tick_div});
      write_reg(`DSI_REG_GPIO, {28'd0, e.gpio});
      check_value("dsi_reset_n_o", dsi_reset_n_o, e.gpio[0]);
      check_value("dsi_gpio_o", dsi_gpio_o, e.gpio[3:1]);
      write_reg(`DSI_REG_LANE_CTRL, {19'd0, e.lane_ctrl});
      read_reg(`DSI_REG_GPIO, rdata);
      check_value("host_rdata_o GPIO", rdata, {28'd0, e.gpio});
      read_reg(`DSI_REG_LANE_CTRL, rdata);
      check_value("host_rdata_o LANE_CTRL", rdata, {19'd0, e.lane_ctrl});
      if (e.lp_en)
         send_lp(e);
      write_reg(`DSI_REG_CTL, ctl_wr);
      wait_hs_entry(e);
      stream_hs(e);
      read_reg(`DSI_REG_CTL, rdata);
      check_value("host_rdata_o CTL", rdata, ctl_rd);
      write_reg(`DSI_REG_CTL, 32'd0);
      wait_stop(e);
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////

   initial begin : main
      rst_n_dsi    = 1'b0;
      host_addr_i  = '0;
      host_wdata_i = '0;
      host_wr_i    = 1'b0;
      hs_data_i    = '0;
      hs_valid_i   = 1'b0;
      repeat (8) @(negedge clk_dsi_i);
      rst_n_dsi = 1'b1;
      @(negedge clk_dsi_i);
      check_value("lp lines after reset",
                  {dsi_lp_p_o, dsi_lp_n_o, dsi_clk_lp_p_o, dsi_clk_lp_n_o}, 8'hFF);
      check_value("serdes_oe_o after reset", serdes_oe_o, 4'd0);
      check_value("serdes_data_o after reset", serdes_data_o, 32'd0);
      check_value("dsi_reset_n_o after reset", dsi_reset_n_o, 1'b0);
      check_value("dsi_gpio_o after reset", dsi_gpio_o, 3'd0);
      check_value("host_rdata_o after reset", host_rdata_o, 32'd0);
      for (int t = 0; t < NUM_ENTRIES; t++)
         run_entry(TESTS[t]);
      if (count_assert_failures() != 0) begin
         stop_run("a lane line state assertion failed during the run");
      end else begin
         $display("ALL CHECKS PASSED");
         $finish;
      end
   end

   // a failing lane assertion ends the run
   always @(negedge clk_dsi_i) begin
      if (count_assert_failures() != 0)
         stop_run("a lane line state assertion failed");
   end

   // limit from the table length and its slowest tick divisor
   initial begin : watchdog
      int max_div;
      int limit_cycles;
      max_div = 0;
      foreach (TESTS[t])
         if (int'(TESTS[t].tick_div) > max_div)
            max_div = TESTS[t].tick_div;
      limit_cycles = 20 + NUM_ENTRIES * entry_cycles(max_div);
      #(limit_cycles * CLK_PERIOD);
      stop_run("watchdog timeout, the tests did not finish in time");
   end

endmodule

// ==== vlog.f ====
+incdir+design
design/dsi_pkg.sv
design/dsi_lane_ctrl_if.sv
design/dsi_csr_regs.sv
design/dsi_dphy_lane.sv
design/dsi_core.sv
tb/dsi_core_props.sv
tb/dsi_core_tb.sv

// ==== Bender.yml ====
package:
  name: dsi_core

export_include_dirs:
  - design

sources:
  - design/dsi_pkg.sv
  - design/dsi_lane_ctrl_if.sv
  - design/dsi_csr_regs.sv
  - design/dsi_dphy_lane.sv
  - design/dsi_core.sv
  - target: test
    files:
      - tb/dsi_core_props.sv
      - tb/dsi_core_tb.sv
